/* src.f */
src/fir_pkg.sv
src/fir_axi_decode.sv
src/fir_coef_bank.sv
src/fir_tap_chain.sv
src/fir_axi_top.sv
tests/fir_tb.sv

/* run.sh */
#!/bin/sh
# build and run the FIR testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module fir_tb -f src.f -o fir_sim

./obj_dir/fir_sim | tee sim.log

if grep -q "Test FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

/* tests/fir_tb.sv */
`timescale 1ns/100ps

module fir_tb;
	import fir_pkg::*;

	localparam int TAP_NR = 8;
	localparam int COEF_MAG = 17;
	localparam int CLK_NS = 8;
	// cycle budget per test
	localparam int T1_CYC = 150;
	localparam int T2_CYC = 250;
	localparam int T3_CYC = 260;
	localparam int T4_CYC = 250;
	localparam int T5_CYC = 700;
	localparam int WATCHDOG_NS = 2 * (T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC) * CLK_NS;
	// register word indices
	localparam int W_SWITCHES = 20;
	localparam int W_COEF = 32;
	localparam int W_UNMAPPED = 7;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	axi_addr_t S_AXI_AWADDR;
	logic [2:0] S_AXI_AWPROT;
	logic S_AXI_AWVALID;
	logic S_AXI_AWREADY;
	axi_data_t S_AXI_WDATA;
	logic [3:0] S_AXI_WSTRB;
	logic S_AXI_WVALID;
	logic S_AXI_WREADY;
	logic [1:0] S_AXI_BRESP;
	logic S_AXI_BVALID;
	logic S_AXI_BREADY;
	axi_addr_t S_AXI_ARADDR;
	logic [2:0] S_AXI_ARPROT;
	logic S_AXI_ARVALID;
	logic S_AXI_ARREADY;
	axi_data_t S_AXI_RDATA;
	logic [1:0] S_AXI_RRESP;
	logic S_AXI_RVALID;
	logic S_AXI_RREADY;
	sample_t fir_in;
	sample_t fir_out;
	logic [6:0] leds_out;

	// reference model state with hist[0] newest
	sample_t hist [TAP_NR];
	coef_t model_coef [TAP_NR];
	logic model_fir_en;
	logic model_on;
	// predictions in flight through the 3 stage pipe
	sample_t expq [$];
	logic [15:0] lfsr;
	int errors;
	int stream_checks;
	int tests_passed;
	int tests_failed;
	int test_err_start;

	fir_axi_top dut0 (.*);

	initial begin
		S_AXI_ACLK = 1'b0;
		forever #(CLK_NS / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// one step per bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// full precision sum then shift and keep the low sample bits
	function automatic sample_t filter_predict();
		longint sum;
		sum = 0;
		for (int k = 0; k < TAP_NR; k++)
			sum += longint'(hist[k]) * longint'(model_coef[k]);
		return sample_t'(sum >>> COEF_MAG);
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
			input logic [31:0] act_v);
		errors++;
		$display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp_v, act_v);
	endtask

	// stream model checks against the prediction from 3 edges back
	always @(posedge S_AXI_ACLK) begin
		sample_t pred;
		sample_t exp_out;
		if (model_on) begin
			for (int k = TAP_NR - 1; k > 0; k--)
				hist[k] = hist[k - 1];
			hist[0] = fir_in;
			pred = model_fir_en ? filter_predict() : fir_in;
			expq.push_back(pred);
			if (expq.size() > 3) begin
				exp_out = expq.pop_front();
				stream_checks++;
				if (fir_out !== exp_out)
					report_mismatch("fir_out", {18'b0, exp_out}, {18'b0, fir_out});
			end
		end
	end

	task automatic axi_write(input int word, input axi_data_t data);
		@(posedge S_AXI_ACLK);
		S_AXI_AWADDR <= axi_addr_t'(word * 4);
		S_AXI_WDATA <= data;
		S_AXI_AWVALID <= 1'b1;
		S_AXI_WVALID <= 1'b1;
		S_AXI_BREADY <= 1'b1;
		@(posedge S_AXI_ACLK);
		// ready seen high marks the accepting edge
		while (!S_AXI_AWREADY)
			@(posedge S_AXI_ACLK);
		if (S_AXI_WREADY !== 1'b1)
			report_mismatch("S_AXI_WREADY", 32'd1, {31'b0, S_AXI_WREADY});
		S_AXI_AWVALID <= 1'b0;
		S_AXI_WVALID <= 1'b0;
		@(posedge S_AXI_ACLK);
		while (!S_AXI_BVALID)
			@(posedge S_AXI_ACLK);
		if (S_AXI_BRESP !== 2'b00)
			report_mismatch("S_AXI_BRESP", 32'd0, {30'b0, S_AXI_BRESP});
		S_AXI_BREADY <= 1'b0;
	endtask

	task automatic axi_read(input int word, output axi_data_t data);
		@(posedge S_AXI_ACLK);
		S_AXI_ARADDR <= axi_addr_t'(word * 4);
		S_AXI_ARVALID <= 1'b1;
		S_AXI_RREADY <= 1'b1;
		@(posedge S_AXI_ACLK);
		while (!S_AXI_ARREADY)
			@(posedge S_AXI_ACLK);
		S_AXI_ARVALID <= 1'b0;
		@(posedge S_AXI_ACLK);
		while (!S_AXI_RVALID)
			@(posedge S_AXI_ACLK);
		data = S_AXI_RDATA;
		if (S_AXI_RRESP !== 2'b00)
			report_mismatch("S_AXI_RRESP", 32'd0, {30'b0, S_AXI_RRESP});
		S_AXI_RREADY <= 1'b0;
	endtask

	task automatic expect_read(input int word, input axi_data_t exp_v);
		axi_data_t rd;
		axi_read(word, rd);
		if (rd !== exp_v)
			report_mismatch($sformatf("S_AXI_RDATA word %0d", word), exp_v, rd);
	endtask

	task automatic write_switches(input axi_data_t data);
		axi_write(W_SWITCHES, data);
		model_fir_en = data[1];
	endtask

	// sign from bit 31 over magnitude bits 16..0
	task automatic load_coef(input int k, input axi_data_t data);
		axi_write(W_COEF + k, data);
		model_coef[k] = coef_t'({data[31], data[16:0]});
	endtask

	// alt_sign forces odd taps negative
	task automatic load_random_coefs(input logic alt_sign);
		axi_data_t data;
		for (int k = 0; k < TAP_NR; k++) begin
			data = rand_bits(32);
			if (alt_sign)
				data[31] = k[0];
			load_coef(k, data);
		end
	endtask

	task automatic drive_random(input int n);
		repeat (n) begin
			@(posedge S_AXI_ACLK);
			fir_in <= sample_t'(rand_bits(14));
		end
	endtask

	// zero input long enough to empty the taps
	task automatic drive_zero(input int n);
		repeat (n) begin
			@(posedge S_AXI_ACLK);
			fir_in <= '0;
		end
	endtask

	task automatic finish_test(input int num, input string name);
		if (errors == test_err_start) begin
			tests_passed++;
			$display("test %0d %s passed", num, name);
		end else begin
			tests_failed++;
			$display("test %0d %s failed, %0d errors", num, name, errors - test_err_start);
		end
		test_err_start = errors;
	endtask

	initial begin
		axi_data_t wd;
		S_AXI_ARESETN <= 1'b0;
		S_AXI_AWADDR <= '0;
		S_AXI_AWPROT <= 3'b000;
		S_AXI_AWVALID <= 1'b0;
		S_AXI_WDATA <= '0;
		S_AXI_WSTRB <= 4'hf;
		S_AXI_WVALID <= 1'b0;
		S_AXI_BREADY <= 1'b0;
		S_AXI_ARADDR <= '0;
		S_AXI_ARPROT <= 3'b000;
		S_AXI_ARVALID <= 1'b0;
		S_AXI_RREADY <= 1'b0;
		fir_in <= '0;
		lfsr = 16'd17343;
		errors = 0;
		stream_checks = 0;
		tests_passed = 0;
		tests_failed = 0;
		test_err_start = 0;
		model_on = 1'b0;
		model_fir_en = 1'b0;
		for (int k = 0; k < TAP_NR; k++) begin
			hist[k] = '0;
			model_coef[k] = '0;
		end
		// registers hold zero out of reset
		repeat (3) expq.push_back('0);
		repeat (5) @(posedge S_AXI_ACLK);
		S_AXI_ARESETN <= 1'b1;
		model_on <= 1'b1;

		// bypassed after reset then id and config words
		drive_random(20);
		drive_zero(12);
		expect_read(0, 32'h4649_5220);
		expect_read(1, 32'h302E_3320);
		expect_read(4, 32'd8);
		expect_read(12, 32'd17);
		expect_read(W_SWITCHES, 32'd0);
		expect_read(W_UNMAPPED, 32'd0);
		expect_read(W_COEF, 32'd0);
		finish_test(1, "reset and identification");

		for (int i = 0; i < 8; i++) begin
			wd = rand_bits(32);
			write_switches(wd);
			@(posedge S_AXI_ACLK);
			if (leds_out !== wd[6:0])
				report_mismatch("leds_out", {25'b0, wd[6:0]}, {25'b0, leds_out});
			expect_read(W_SWITCHES, wd);
		end
		write_switches('0);
		drive_zero(4);
		finish_test(2, "switch register");

		drive_random(200);
		drive_zero(12);
		finish_test(3, "bypass stream");

		load_random_coefs(1'b1);
		// tap words stay write-only once loaded
		expect_read(W_COEF + 1, 32'd0);
		write_switches(32'h2);
		drive_zero(12);
		@(posedge S_AXI_ACLK);
		fir_in <= 14'sd8191;
		drive_zero(TAP_NR + 4);
		finish_test(4, "impulse response");

		// rewrites only while the taps hold zeros
		load_random_coefs(1'b0);
		drive_zero(12);
		drive_random(150);
		drive_zero(12);
		load_random_coefs(1'b0);
		drive_zero(12);
		drive_random(150);
		drive_zero(12);
		write_switches('0);
		drive_zero(4);
		drive_random(40);
		drive_zero(12);
		finish_test(5, "random filtering");

		$display("tests passed %0d, failed %0d, errors %0d, stream checks %0d",
			tests_passed, tests_failed, errors, stream_checks);
		if (tests_failed == 0 && errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// run limit from the summed test budgets
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, a test did not complete", WATCHDOG_NS);
		$display("Test FAILED");
		$finish;
	end

endmodule

/* src/fir_axi_top.sv */
`timescale 1ns/100ps

module fir_axi_top #(
	parameter int TAP_NR = 8,
	parameter int COEF_MAG = 17
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input fir_pkg::axi_addr_t S_AXI_AWADDR,
	input logic [2:0] S_AXI_AWPROT,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input fir_pkg::axi_data_t S_AXI_WDATA,
	input logic [3:0] S_AXI_WSTRB,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input fir_pkg::axi_addr_t S_AXI_ARADDR,
	input logic [2:0] S_AXI_ARPROT,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output fir_pkg::axi_data_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	input fir_pkg::sample_t fir_in,
	output fir_pkg::sample_t fir_out,
	output logic [6:0] leds_out
);
	import fir_pkg::*;

	// decode to bank
	logic [TAP_NR-1:0] coef_wr_en;
	coef_t coef_wr_data;
	// bank to tap chain
	coef_t coefs [TAP_NR];
	logic fir_en;

	// register file and bus slave
	fir_axi_decode #(
		.TAP_NR(TAP_NR),
		.COEF_MAG(COEF_MAG)
	) u_decode (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.S_AXI_AWADDR(S_AXI_AWADDR),
		.S_AXI_AWPROT(S_AXI_AWPROT),
		.S_AXI_AWVALID(S_AXI_AWVALID),
		.S_AXI_AWREADY(S_AXI_AWREADY),
		.S_AXI_WDATA(S_AXI_WDATA),
		.S_AXI_WSTRB(S_AXI_WSTRB),
		.S_AXI_WVALID(S_AXI_WVALID),
		.S_AXI_WREADY(S_AXI_WREADY),
		.S_AXI_BRESP(S_AXI_BRESP),
		.S_AXI_BVALID(S_AXI_BVALID),
		.S_AXI_BREADY(S_AXI_BREADY),
		.S_AXI_ARADDR(S_AXI_ARADDR),
		.S_AXI_ARPROT(S_AXI_ARPROT),
		.S_AXI_ARVALID(S_AXI_ARVALID),
		.S_AXI_ARREADY(S_AXI_ARREADY),
		.S_AXI_RDATA(S_AXI_RDATA),
		.S_AXI_RRESP(S_AXI_RRESP),
		.S_AXI_RVALID(S_AXI_RVALID),
		.S_AXI_RREADY(S_AXI_RREADY),
		.coef_wr_en(coef_wr_en),
		.coef_wr_data(coef_wr_data),
		.fir_en(fir_en),
		.leds_out(leds_out)
	);

	fir_coef_bank #(
		.TAP_NR(TAP_NR)
	) u_coef_bank (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.coef_wr_en(coef_wr_en),
		.coef_wr_data(coef_wr_data),
		.coefs(coefs)
	);

	// filter datapath, 3 cycle latency
	fir_tap_chain #(
		.TAP_NR(TAP_NR),
		.COEF_MAG(COEF_MAG)
	) u_tap_chain (
		.S_AXI_ACLK(S_AXI_ACLK),
		.S_AXI_ARESETN(S_AXI_ARESETN),
		.fir_in(fir_in),
		.coefs(coefs),
		.fir_en(fir_en),
		.fir_out(fir_out)
	);

endmodule

/* src/fir_tap_chain.sv */
`timescale 1ns/100ps

module fir_tap_chain #(
	parameter int TAP_NR = 8,
	parameter int COEF_MAG = 17
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input fir_pkg::sample_t fir_in,
	input fir_pkg::coef_t coefs [TAP_NR],
	input logic fir_en,
	output fir_pkg::sample_t fir_out
);
	import fir_pkg::*;

	localparam int PROD_W = SAMPLE_W + COEF_W;

	// input register, shared by all taps
	sample_t x_q;
	// second stage of the bypass delay, x_q is the first
	sample_t byp_q;
	logic signed [PROD_W-1:0] prod [TAP_NR];
	// transposed partial sums, acc[0] is the head
	acc_t acc [TAP_NR];
	acc_t acc_scaled;

	// one multiplier per tap
	always_comb begin
		for (int k = 0; k < TAP_NR; k++)
			prod[k] = x_q * coefs[k];
	end

	// stage 1 input register
	// stage 2 accumulator chain
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			x_q <= '0;
			byp_q <= '0;
			for (int k = 0; k < TAP_NR; k++)
				acc[k] <= '0;
		end else begin
			x_q <= fir_in;
			byp_q <= x_q;
			// each stage adds on top of the later tap
			for (int k = 0; k < TAP_NR - 1; k++)
				acc[k] <= acc[k + 1] + acc_t'(prod[k]);
			// last tap starts from zero
			acc[TAP_NR - 1] <= acc_t'(prod[TAP_NR - 1]);
		end
	end

	// drop the fraction bits, sign kept
	assign acc_scaled = acc[0] >>> COEF_MAG;

	// stage 3, low bits kept and wrap on overflow
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			fir_out <= '0;
		else if (fir_en)
			fir_out <= sample_t'(acc_scaled[SAMPLE_W-1:0]);
		else
			fir_out <= byp_q;
	end

endmodule

/* src/fir_coef_bank.sv */
`timescale 1ns/100ps

module fir_coef_bank #(
	parameter int TAP_NR = 8
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input logic [TAP_NR-1:0] coef_wr_en,
	input fir_pkg::coef_t coef_wr_data,
	output fir_pkg::coef_t coefs [TAP_NR]
);
	import fir_pkg::*;

	// local copy, coefs driven from it
	coef_t coef_q [TAP_NR];

	// one register per tap
	// loads on its own strobe bit
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			for (int k = 0; k < TAP_NR; k++)
				coef_q[k] <= '0;
		end else begin
			for (int k = 0; k < TAP_NR; k++) begin
				if (coef_wr_en[k])
					coef_q[k] <= coef_wr_data;
			end
		end
	end

	// straight to the multipliers
	always_comb begin
		for (int k = 0; k < TAP_NR; k++)
			coefs[k] = coef_q[k];
	end

endmodule

/* src/fir_axi_decode.sv */
`timescale 1ns/100ps

module fir_axi_decode #(
	parameter int TAP_NR = 8,
	parameter int COEF_MAG = 17
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	input fir_pkg::axi_addr_t S_AXI_AWADDR,
	input logic [2:0] S_AXI_AWPROT,
	input logic S_AXI_AWVALID,
	output logic S_AXI_AWREADY,
	input fir_pkg::axi_data_t S_AXI_WDATA,
	input logic [3:0] S_AXI_WSTRB,
	input logic S_AXI_WVALID,
	output logic S_AXI_WREADY,
	output logic [1:0] S_AXI_BRESP,
	output logic S_AXI_BVALID,
	input logic S_AXI_BREADY,
	input fir_pkg::axi_addr_t S_AXI_ARADDR,
	input logic [2:0] S_AXI_ARPROT,
	input logic S_AXI_ARVALID,
	output logic S_AXI_ARREADY,
	output fir_pkg::axi_data_t S_AXI_RDATA,
	output logic [1:0] S_AXI_RRESP,
	output logic S_AXI_RVALID,
	input logic S_AXI_RREADY,
	output logic [TAP_NR-1:0] coef_wr_en,
	output fir_pkg::coef_t coef_wr_data,
	output logic fir_en,
	output logic [6:0] leds_out
);
	import fir_pkg::*;

	// latched word indices
	reg_idx_t axi_awaddr;
	reg_idx_t axi_araddr;
	// low while a write response is outstanding
	logic aw_en;
	logic reg_wren;
	logic reg_rden;
	axi_data_t rd_mux;
	axi_data_t switches;

	// responses are always okay
	assign S_AXI_BRESP = 2'b00;
	assign S_AXI_RRESP = 2'b00;

	// address and data accepted together, one cycle ready pulse
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			aw_en <= 1'b1;
		end else if (!S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && aw_en) begin
			S_AXI_AWREADY <= 1'b1;
			S_AXI_WREADY <= 1'b1;
			aw_en <= 1'b0;
		end else begin
			S_AXI_AWREADY <= 1'b0;
			S_AXI_WREADY <= 1'b0;
			// response taken, next write may start
			if (S_AXI_BREADY && S_AXI_BVALID)
				aw_en <= 1'b1;
		end
	end

	// word index taken when the write is first seen
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WVALID && aw_en)
			axi_awaddr <= S_AXI_AWADDR[AXI_ADDR_W-1:ADDR_LSB];
	end

	assign reg_wren = S_AXI_AWREADY && S_AXI_AWVALID && S_AXI_WREADY && S_AXI_WVALID;

	// write response
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_BVALID <= 1'b0;
		else if (reg_wren && !S_AXI_BVALID)
			S_AXI_BVALID <= 1'b1;
		else if (S_AXI_BREADY && S_AXI_BVALID)
			S_AXI_BVALID <= 1'b0;
	end

	// switch register, cleared so the filter starts bypassed
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			switches <= '0;
		else if (reg_wren && axi_awaddr == REG_SWITCHES)
			switches <= S_AXI_WDATA;
	end

	assign fir_en = switches[SWITCH_FIR_EN];
	assign leds_out = switches[LED_W-1:0];

	// one strobe per tap word
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN) begin
			coef_wr_en <= '0;
		end else begin
			for (int k = 0; k < TAP_NR; k++)
				coef_wr_en[k] <= reg_wren && (axi_awaddr == reg_idx_t'(COEF_BASE + k));
		end
	end

	// sign from bit 31, magnitude bits from the bottom
	always_ff @(posedge S_AXI_ACLK) begin
		if (reg_wren)
			coef_wr_data <= {S_AXI_WDATA[AXI_DATA_W-1], S_AXI_WDATA[COEF_W-2:0]};
	end

	// read address, one cycle ready pulse
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_ARREADY <= 1'b0;
		else if (!S_AXI_ARREADY && S_AXI_ARVALID)
			S_AXI_ARREADY <= 1'b1;
		else
			S_AXI_ARREADY <= 1'b0;
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARREADY && S_AXI_ARVALID)
			axi_araddr <= S_AXI_ARADDR[AXI_ADDR_W-1:ADDR_LSB];
	end

	assign reg_rden = S_AXI_ARREADY && S_AXI_ARVALID && !S_AXI_RVALID;

	// read data valid until the host takes it
	always_ff @(posedge S_AXI_ACLK) begin
		if (!S_AXI_ARESETN)
			S_AXI_RVALID <= 1'b0;
		else if (reg_rden)
			S_AXI_RVALID <= 1'b1;
		else if (S_AXI_RVALID && S_AXI_RREADY)
			S_AXI_RVALID <= 1'b0;
	end

	// read mux, tap words and holes give 0
	always_comb begin
		case (axi_araddr)
			REG_NAME: rd_mux = PROG_NAME;
			REG_VER: rd_mux = PROG_VER;
			REG_TAP_NR: rd_mux = axi_data_t'(TAP_NR);
			REG_COEF_MAG: rd_mux = axi_data_t'(COEF_MAG);
			REG_SWITCHES: rd_mux = switches;
			default: rd_mux = '0;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK) begin
		if (reg_rden)
			S_AXI_RDATA <= rd_mux;
	end

endmodule

/* src/fir_pkg.sv */
package fir_pkg;

	// bus widths
	localparam int AXI_ADDR_W = 16;
	localparam int AXI_DATA_W = 32;
	// byte offset bits dropped from the bus address
	localparam int ADDR_LSB = 2;
	localparam int REG_IDX_W = AXI_ADDR_W - ADDR_LSB;

	// datapath widths
	localparam int SAMPLE_W = 14;
	localparam int COEF_W = 18;
	// tap count ceiling, sets the accumulator guard bits
	localparam int MAX_TAP_NR = 16;
	localparam int GUARD_W = $clog2(MAX_TAP_NR);
	localparam int ACC_W = SAMPLE_W + COEF_W + GUARD_W;

	typedef logic signed [SAMPLE_W-1:0] sample_t;
	typedef logic signed [COEF_W-1:0] coef_t;
	typedef logic signed [ACC_W-1:0] acc_t;
	typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
	typedef logic [AXI_DATA_W-1:0] axi_data_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// read-only words
	localparam reg_idx_t REG_NAME = 14'd0;
	localparam reg_idx_t REG_VER = 14'd1;
	localparam reg_idx_t REG_TAP_NR = 14'd4;
	localparam reg_idx_t REG_COEF_MAG = 12;

	// read-write control word
	localparam reg_idx_t REG_SWITCHES = 14'd20;
	// first coefficient word, one word per tap, write-only
	localparam int COEF_BASE = 32;

	// id text, four ascii chars per word
	localparam axi_data_t PROG_NAME = "FIR ";
	localparam axi_data_t PROG_VER = "0.3 ";

	// switch bits
	localparam int SWITCH_FIR_EN = 1;
	localparam int LED_W = 7;

endpackage
